// File: all.f
rtl/cpu_pkg.sv
rtl/exec_if.sv
rtl/instr_buffer.sv
rtl/decoder.sv
rtl/dispatch.sv
rtl/regfile.sv
rtl/execute.sv
rtl/cpu_top.sv
verif/tb_cpu_top.sv

// File: rtl/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN        = 32;
    localparam int NUM_REGS    = 32;
    localparam int ISSUE_WIDTH = 2;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [2:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_OR,
        ALU_LUI   // Pass the immediate through
    } alu_op_e;

    // Opcode fields, matched against the top of the instruction word
    localparam logic [16:0] OPC_ADD_W   = 17'h00020;  // instr[31:15]
    localparam logic [16:0] OPC_SUB_W   = 17'h00022;
    localparam logic [16:0] OPC_OR      = 17'h0002a;
    localparam logic [9:0]  OPC_ADDI_W  = 10'h00a;    // instr[31:22]
    localparam logic [6:0]  OPC_LU12I_W = 7'h0a;      // instr[31:25]

    typedef struct packed {
        word_t pc;
        word_t instr;
    } ib_entry_t;

    typedef struct packed {
        word_t     pc;
        alu_op_e   op;
        reg_addr_t rd;
        reg_addr_t rj;
        reg_addr_t rk;
        word_t     imm;
        logic      use_imm;  // Immediate replaces the rk operand
        logic      wen;
    } uop_t;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        logic      wen;
        reg_addr_t wnum;
        word_t     wdata;
    } wb_t;

endpackage

// File: rtl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter int IB_DEPTH = 8
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [1:0]          fetch_valid_i,   // Slot 1 only with slot 0
    input  cpu_pkg::word_t      fetch_pc_i,
    input  cpu_pkg::word_t      fetch_instr0_i,
    input  cpu_pkg::word_t      fetch_instr1_i,
    output logic                fetch_stall_o,
    output logic                commit0_valid_o,
    output cpu_pkg::word_t      commit0_pc_o,
    output logic                commit0_wen_o,
    output cpu_pkg::reg_addr_t  commit0_wnum_o,
    output cpu_pkg::word_t      commit0_wdata_o,
    output logic                commit1_valid_o,
    output cpu_pkg::word_t      commit1_pc_o,
    output logic                commit1_wen_o,
    output cpu_pkg::reg_addr_t  commit1_wnum_o,
    output cpu_pkg::word_t      commit1_wdata_o
);

    cpu_pkg::ib_entry_t [cpu_pkg::ISSUE_WIDTH-1:0] head;
    logic [1:0]                                    head_valid;
    logic [1:0]                                    accept;
    cpu_pkg::reg_addr_t [3:0]                      rf_raddr;
    cpu_pkg::word_t [3:0]                          rf_rdata;
    cpu_pkg::wb_t [cpu_pkg::ISSUE_WIDTH-1:0]       wb;

    exec_if ex_bus ();

    instr_buffer #(
        .IB_DEPTH (IB_DEPTH)
    ) u_instr_buffer (
        .clk           (clk),
        .rst           (rst),
        .push_valid_i  (fetch_valid_i),
        .push_pc_i     (fetch_pc_i),
        .push_instr0_i (fetch_instr0_i),
        .push_instr1_i (fetch_instr1_i),
        .accept_i      (accept),
        .full_o        (fetch_stall_o),
        .head_o        (head),
        .head_valid_o  (head_valid)
    );

    dispatch u_dispatch (
        .clk          (clk),
        .rst          (rst),
        .head_i       (head),
        .head_valid_i (head_valid),
        .rf_rdata_i   (rf_rdata),
        .wb_i         (wb),
        .accept_o     (accept),
        .rf_raddr_o   (rf_raddr),
        .ex           (ex_bus.issue)
    );

    regfile u_regfile (
        .clk     (clk),
        .rst     (rst),
        .we_i    ({wb[1].wen, wb[0].wen}),
        .waddr_i ({wb[1].wnum, wb[0].wnum}),
        .wdata_i ({wb[1].wdata, wb[0].wdata}),
        .raddr_i (rf_raddr),
        .rdata_o (rf_rdata)
    );

    execute u_execute (
        .clk  (clk),
        .rst  (rst),
        .ex   (ex_bus.exec),
        .wb_o (wb)
    );

    // Commit ports show the writeback register directly
    assign commit0_valid_o = wb[0].valid;
    assign commit0_pc_o    = wb[0].pc;
    assign commit0_wen_o   = wb[0].wen;
    assign commit0_wnum_o  = wb[0].wnum;
    assign commit0_wdata_o = wb[0].wdata;
    assign commit1_valid_o = wb[1].valid;
    assign commit1_pc_o    = wb[1].pc;
    assign commit1_wen_o   = wb[1].wen;
    assign commit1_wnum_o  = wb[1].wnum;
    assign commit1_wdata_o = wb[1].wdata;

endmodule

// File: rtl/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  cpu_pkg::word_t instr_i,
    input  cpu_pkg::word_t pc_i,
    output cpu_pkg::uop_t  uop_o
);

    cpu_pkg::reg_addr_t rd, rj, rk;

    assign rd = instr_i[4:0];
    assign rj = instr_i[9:5];
    assign rk = instr_i[14:10];

    always_comb begin
        // Unused sources stay at r0 so they never look like a dependency
        uop_o    = '0;
        uop_o.pc = pc_i;
        uop_o.rd = rd;
        if (instr_i[31:15] == cpu_pkg::OPC_ADD_W) begin
            uop_o.op  = cpu_pkg::ALU_ADD;
            uop_o.rj  = rj;
            uop_o.rk  = rk;
            uop_o.wen = 1'b1;
        end else if (instr_i[31:15] == cpu_pkg::OPC_SUB_W) begin
            uop_o.op  = cpu_pkg::ALU_SUB;
            uop_o.rj  = rj;
            uop_o.rk  = rk;
            uop_o.wen = 1'b1;
        end else if (instr_i[31:15] == cpu_pkg::OPC_OR) begin
            uop_o.op  = cpu_pkg::ALU_OR;
            uop_o.rj  = rj;
            uop_o.rk  = rk;
            uop_o.wen = 1'b1;
        end else if (instr_i[31:22] == cpu_pkg::OPC_ADDI_W) begin
            uop_o.op      = cpu_pkg::ALU_ADD;
            uop_o.rj      = rj;
            uop_o.imm     = {{20{instr_i[21]}}, instr_i[21:10]};  // si12
            uop_o.use_imm = 1'b1;
            uop_o.wen     = 1'b1;
        end else if (instr_i[31:25] == cpu_pkg::OPC_LU12I_W) begin
            uop_o.op      = cpu_pkg::ALU_LUI;
            uop_o.imm     = {instr_i[24:5], 12'b0};  // si20 in the upper bits
            uop_o.use_imm = 1'b1;
            uop_o.wen     = 1'b1;
        end
        if (rd == '0) begin
            uop_o.wen = 1'b0;  // r0 is never written
        end
    end

endmodule

// File: rtl/dispatch.sv
`timescale 1ns/1ps

module dispatch (
    input  logic                                            clk,
    input  logic                                            rst,
    input  cpu_pkg::ib_entry_t [cpu_pkg::ISSUE_WIDTH-1:0]   head_i,
    input  logic [1:0]                                      head_valid_i,
    input  cpu_pkg::word_t [3:0]                            rf_rdata_i,
    input  cpu_pkg::wb_t [cpu_pkg::ISSUE_WIDTH-1:0]         wb_i,
    output logic [1:0]                                      accept_o,
    output cpu_pkg::reg_addr_t [3:0]                        rf_raddr_o,
    exec_if.issue                                           ex
);

    cpu_pkg::uop_t  [cpu_pkg::ISSUE_WIDTH-1:0] uop;
    cpu_pkg::word_t [3:0]                      opnd;
    logic                                      dep;

    for (genvar i = 0; i < cpu_pkg::ISSUE_WIDTH; i++) begin : g_dec
        decoder u_decoder (
            .instr_i (head_i[i].instr),
            .pc_i    (head_i[i].pc),
            .uop_o   (uop[i])
        );
        assign rf_raddr_o[2*i]   = uop[i].rj;
        assign rf_raddr_o[2*i+1] = uop[i].rk;
    end

    // Slot 1 reading what slot 0 writes waits a cycle
    assign dep = uop[0].wen && (uop[0].rd == uop[1].rj || uop[0].rd == uop[1].rk);

    assign accept_o[0] = head_valid_i[0];
    assign accept_o[1] = head_valid_i[0] && head_valid_i[1] && !dep;

    // Lowest priority first so the youngest producer overrides
    // wen is only ever set for a nonzero rd
    always_comb begin
        for (int p = 0; p < 4; p++) begin
            opnd[p] = rf_rdata_i[p];
            for (int s = 0; s < cpu_pkg::ISSUE_WIDTH; s++) begin
                if (wb_i[s].wen && wb_i[s].wnum == rf_raddr_o[p]) begin
                    opnd[p] = wb_i[s].wdata;
                end
            end
            for (int s = 0; s < cpu_pkg::ISSUE_WIDTH; s++) begin
                if (ex.slot_valid[s] && ex.uop[s].wen && ex.uop[s].rd == rf_raddr_o[p]) begin
                    opnd[p] = ex.result[s];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex.slot_valid <= '0;
        end else begin
            ex.slot_valid <= accept_o;  // Slot not issued goes in as a bubble
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < cpu_pkg::ISSUE_WIDTH; i++) begin
            ex.uop[i]   <= uop[i];
            ex.src_a[i] <= opnd[2*i];
            ex.src_b[i] <= uop[i].use_imm ? uop[i].imm : opnd[2*i+1];
        end
    end

endmodule

// File: rtl/exec_if.sv
`timescale 1ns/1ps

interface exec_if;

    logic [cpu_pkg::ISSUE_WIDTH-1:0]                slot_valid;
    cpu_pkg::uop_t  [cpu_pkg::ISSUE_WIDTH-1:0]      uop;
    cpu_pkg::word_t [cpu_pkg::ISSUE_WIDTH-1:0]      src_a;
    cpu_pkg::word_t [cpu_pkg::ISSUE_WIDTH-1:0]      src_b;
    cpu_pkg::word_t [cpu_pkg::ISSUE_WIDTH-1:0]      result;  // Combinational ALU out

    modport issue (
        output slot_valid, uop, src_a, src_b,
        input  result
    );

    modport exec (
        input  slot_valid, uop, src_a, src_b,
        output result
    );

endinterface

// File: rtl/execute.sv
`timescale 1ns/1ps

module execute (
    input  logic                                        clk,
    input  logic                                        rst,
    exec_if.exec                                        ex,
    output cpu_pkg::wb_t [cpu_pkg::ISSUE_WIDTH-1:0]     wb_o
);

    function automatic cpu_pkg::word_t alu(
        input cpu_pkg::alu_op_e op,
        input cpu_pkg::word_t   a,
        input cpu_pkg::word_t   b
    );
        case (op)
            cpu_pkg::ALU_ADD: return a + b;
            cpu_pkg::ALU_SUB: return a - b;
            cpu_pkg::ALU_OR:  return a | b;
            cpu_pkg::ALU_LUI: return b;  // Immediate already shifted by decode
            default:          return '0;
        endcase
    endfunction

    // Same lane logic for both slots
    always_comb begin
        for (int i = 0; i < cpu_pkg::ISSUE_WIDTH; i++) begin
            ex.result[i] = alu(ex.uop[i].op, ex.src_a[i], ex.src_b[i]);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < cpu_pkg::ISSUE_WIDTH; i++) begin
            if (rst) begin
                wb_o[i].valid <= 1'b0;
                wb_o[i].wen   <= 1'b0;
            end else begin
                wb_o[i].valid <= ex.slot_valid[i];
                wb_o[i].wen   <= ex.slot_valid[i] && ex.uop[i].wen;
            end
            wb_o[i].pc    <= ex.uop[i].pc;
            wb_o[i].wnum  <= ex.uop[i].rd;
            wb_o[i].wdata <= ex.result[i];
        end
    end

endmodule

// File: rtl/instr_buffer.sv
`timescale 1ns/1ps

module instr_buffer #(
    parameter int IB_DEPTH = 8
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic [1:0]                                      push_valid_i,
    input  cpu_pkg::word_t                                  push_pc_i,
    input  cpu_pkg::word_t                                  push_instr0_i,
    input  cpu_pkg::word_t                                  push_instr1_i,
    input  logic [1:0]                                      accept_i,
    output logic                                            full_o,
    output cpu_pkg::ib_entry_t [cpu_pkg::ISSUE_WIDTH-1:0]   head_o,
    output logic [1:0]                                      head_valid_o
);

    localparam int PTR_W = $clog2(IB_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    cpu_pkg::ib_entry_t mem [IB_DEPTH];

    logic [PTR_W-1:0] rd_ptr, wr_ptr;
    logic [PTR_W-1:0] rd_ptr_nx, wr_ptr_nx;
    logic [CNT_W-1:0] count;
    logic [1:0]       push_cnt, pop_cnt;
    logic             push_ok;

    assign rd_ptr_nx = rd_ptr + 1'b1;  // Wraps for free, depth is a power of two
    assign wr_ptr_nx = wr_ptr + 1'b1;

    // Stall while a full pair could not fit
    assign full_o  = count > CNT_W'(IB_DEPTH - 2);
    assign push_ok = !full_o;

    assign push_cnt = push_ok ? {1'b0, push_valid_i[0]} + {1'b0, push_valid_i[1]} : 2'd0;
    assign pop_cnt  = {1'b0, accept_i[0]} + {1'b0, accept_i[1]};

    assign head_o[0]       = mem[rd_ptr];
    assign head_o[1]       = mem[rd_ptr_nx];
    assign head_valid_o[0] = count != '0;
    assign head_valid_o[1] = count > CNT_W'(1);

    always_ff @(posedge clk) begin
        if (push_ok && push_valid_i[0]) begin
            mem[wr_ptr] <= '{pc: push_pc_i, instr: push_instr0_i};
        end
        if (push_ok && push_valid_i[1]) begin
            mem[wr_ptr_nx] <= '{pc: push_pc_i + 32'd4, instr: push_instr1_i};  // Second slot
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            rd_ptr <= rd_ptr + PTR_W'(pop_cnt);
            wr_ptr <= wr_ptr + PTR_W'(push_cnt);
            count  <= count + CNT_W'(push_cnt) - CNT_W'(pop_cnt);
        end
    end

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic [cpu_pkg::ISSUE_WIDTH-1:0]                 we_i,
    input  cpu_pkg::reg_addr_t [cpu_pkg::ISSUE_WIDTH-1:0]   waddr_i,
    input  cpu_pkg::word_t [cpu_pkg::ISSUE_WIDTH-1:0]       wdata_i,
    input  cpu_pkg::reg_addr_t [3:0]                        raddr_i,
    output cpu_pkg::word_t [3:0]                            rdata_o
);

    cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < cpu_pkg::NUM_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // Port 1 assigns last, the younger instruction wins a tie
            for (int p = 0; p < cpu_pkg::ISSUE_WIDTH; p++) begin
                if (we_i[p] && waddr_i[p] != '0) begin
                    regs[waddr_i[p]] <= wdata_i[p];
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < 4; p++) begin
            rdata_o[p] = (raddr_i[p] == '0) ? '0 : regs[raddr_i[p]];
        end
    end

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -j 0 --top-module tb_cpu_top -f all.f -o tb_sim \
    && ./obj_dir/tb_sim | tee sim.log \
    || echo "build or simulation did not complete"
grep -q "TEST PASSED" sim.log 2>/dev/null && exit 0 || exit 1

// File: verif/tb_cpu_top.sv
`timescale 1ns/1ps

module tb_cpu_top;

    localparam int LEN_INDEP = 8;
    localparam int LEN_CHAIN = 12;
    localparam int LEN_ZERO  = 6;
    localparam int LEN_RAND  = 200;
    localparam int WATCHDOG_CYCLES = (LEN_INDEP + LEN_CHAIN + LEN_ZERO + LEN_RAND) * 40 + 200;

    // Opcode fields from the ISA manual
    localparam logic [16:0] OP_ADD = 17'h00020;
    localparam logic [16:0] OP_SUB = 17'h00022;
    localparam logic [16:0] OP_OR  = 17'h0002a;

    typedef struct packed {
        logic [31:0] pc;
        logic        wen;
        logic [4:0]  wnum;
        logic [31:0] data;
    } commit_t;

    logic        clk, rst, fetch_stall;
    logic [1:0]  fetch_valid;
    logic [31:0] fetch_pc, fetch_instr0, fetch_instr1;
    logic        commit0_valid, commit0_wen, commit1_valid, commit1_wen;
    logic [31:0] commit0_pc, commit0_wdata, commit1_pc, commit1_wdata;
    logic [4:0]  commit0_wnum, commit1_wnum;

    logic [31:0] model_regs [32];  // Architectural state of the model
    commit_t     exp_q [$];
    logic [31:0] next_pc, rng;
    logic        stall_seen;
    int          errors, pass_count, fail_count;

    cpu_top #(.IB_DEPTH(8)) uut (
        .clk(clk), .rst(rst), .fetch_valid_i(fetch_valid), .fetch_pc_i(fetch_pc),
        .fetch_instr0_i(fetch_instr0), .fetch_instr1_i(fetch_instr1),
        .fetch_stall_o(fetch_stall),
        .commit0_valid_o(commit0_valid), .commit0_pc_o(commit0_pc),
        .commit0_wen_o(commit0_wen), .commit0_wnum_o(commit0_wnum),
        .commit0_wdata_o(commit0_wdata),
        .commit1_valid_o(commit1_valid), .commit1_pc_o(commit1_pc),
        .commit1_wen_o(commit1_wen), .commit1_wnum_o(commit1_wnum),
        .commit1_wdata_o(commit1_wdata)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] enc_rr(input logic [16:0] opc, input int rd, rj, rk);
        return {opc, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] enc_addi(input int rd, rj, imm);
        return {10'h00a, imm[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] enc_lu12i(input int rd, imm);
        return {7'h0a, imm[19:0], rd[4:0]};
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // Registers limited to r0..r3 so most instructions depend on recent ones
    function automatic logic [31:0] rand_instr();
        rng = xorshift32(rng);
        case (rng % 32'd5)
            0: return enc_rr(OP_ADD, int'(rng[9:8]), int'(rng[11:10]), int'(rng[13:12]));
            1: return enc_rr(OP_SUB, int'(rng[9:8]), int'(rng[11:10]), int'(rng[13:12]));
            2: return enc_rr(OP_OR, int'(rng[9:8]), int'(rng[11:10]), int'(rng[13:12]));
            3: return enc_addi(int'(rng[9:8]), int'(rng[11:10]), int'(rng[31:20]));
            default: return enc_lu12i(int'(rng[9:8]), int'(rng[31:12]));
        endcase
    endfunction

    task automatic predict(input logic [31:0] pc, input logic [31:0] instr);
        commit_t     c;
        logic [31:0] a, b;
        a      = model_regs[instr[9:5]];
        b      = model_regs[instr[14:10]];
        c.pc   = pc;
        c.wnum = instr[4:0];
        c.wen  = 1'b1;
        c.data = '0;
        if (instr[31:15] == OP_ADD) c.data = a + b;
        else if (instr[31:15] == OP_SUB) c.data = a - b;
        else if (instr[31:15] == OP_OR) c.data = a | b;
        else if (instr[31:22] == 10'h00a) c.data = a + {{20{instr[21]}}, instr[21:10]};
        else if (instr[31:25] == 7'h0a) c.data = {instr[24:5], 12'h000};
        else c.wen = 1'b0;  // Unknown encoding retires as a no-op
        if (instr[4:0] == 5'd0) c.wen = 1'b0;
        if (c.wen) model_regs[c.wnum] = c.data;
        exp_q.push_back(c);
    endtask

    // Called 1 ns after a rising edge, returns at the same phase
    task automatic send_group(input logic [1:0] valid, input logic [31:0] i0, i1);
        predict(next_pc, i0);
        if (valid[1]) predict(next_pc + 32'd4, i1);
        fetch_valid  = valid;
        fetch_pc     = next_pc;
        fetch_instr0 = i0;
        fetch_instr1 = i1;
        next_pc      = next_pc + (valid[1] ? 32'd8 : 32'd4);
        while (fetch_stall) begin  // Hold the group until the buffer has room
            stall_seen = 1'b1;
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
        fetch_valid = 2'b00;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drain();
        int waited = 0;
        while (exp_q.size() != 0 && waited < 100) begin
            idle(1);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected commits never arrived", exp_q.size());
            errors++;
            exp_q.delete();
        end
        idle(3);  // Catch stray commits
    endtask

    task automatic check_commit(input int slot, input logic valid, input logic [31:0] pc,
                                input logic wen, input logic [4:0] wnum, input logic [31:0] data);
        commit_t e;
        if (valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("commit on slot %0d at PC %h was not expected", slot, pc);
                errors++;
            end else begin
                e = exp_q.pop_front();
                if (pc !== e.pc) begin
                    $display("FAILED commit%0d_pc_o: got %h expected %h", slot, pc, e.pc);
                    errors++;
                end
                if (wen !== e.wen) begin
                    $display("FAILED commit%0d_wen_o: got %h expected %h", slot, wen, e.wen);
                    errors++;
                end
                if (wnum !== e.wnum) begin
                    $display("FAILED commit%0d_wnum_o: got %h expected %h", slot, wnum, e.wnum);
                    errors++;
                end
                if (e.wen && data !== e.data) begin
                    $display("FAILED commit%0d_wdata_o: got %h expected %h", slot, data, e.data);
                    errors++;
                end
            end
        end else if (valid !== 1'b0) begin
            $display("commit%0d_valid_o is unknown", slot);
            errors++;
        end
    endtask

    // Outputs settle long before the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            check_commit(0, commit0_valid, commit0_pc, commit0_wen, commit0_wnum, commit0_wdata);
            check_commit(1, commit1_valid, commit1_pc, commit1_wen, commit1_wnum, commit1_wdata);
        end
    end

    task automatic report_test(input string name, input int start_errors);
        if (errors == start_errors) begin
            pass_count++;
            $display("%s: pass", name);
        end else begin
            fail_count++;
            $display("%s: %0d errors", name, errors - start_errors);
        end
    endtask

    task automatic test_reset_quiet();
        int e0 = errors;
        repeat (10) begin
            @(negedge clk);
            if (fetch_stall !== 1'b0) begin
                $display("FAILED fetch_stall_o: got %h expected 0", fetch_stall);
                errors++;
            end
            if (commit0_valid !== 1'b0 || commit1_valid !== 1'b0) begin
                $display("FAILED commit valids: got %h %h expected 0 0", commit0_valid,
                         commit1_valid);
                errors++;
            end
        end
        idle(1);
        report_test("reset_quiet", e0);
    endtask

    task automatic test_independent();
        int e0 = errors;
        send_group(2'b11, enc_lu12i(1, 'h12345), enc_addi(2, 0, -5));
        send_group(2'b11, enc_lu12i(3, 'hfffff), enc_addi(4, 0, 'h7ff));
        send_group(2'b11, enc_rr(OP_ADD, 5, 1, 2), enc_rr(OP_SUB, 6, 3, 4));
        send_group(2'b11, enc_rr(OP_OR, 7, 1, 4), enc_addi(8, 3, 1));
        drain();
        report_test("independent_ops", e0);
    endtask

    task automatic test_chains();
        int e0 = errors;
        send_group(2'b11, enc_addi(9, 0, 100), enc_addi(10, 9, -3));  // Split pair
        send_group(2'b11, enc_addi(11, 0, 7), enc_addi(12, 0, 9));
        send_group(2'b11, enc_rr(OP_ADD, 13, 11, 12), enc_rr(OP_SUB, 14, 12, 10));
        idle(1);
        send_group(2'b11, enc_rr(OP_OR, 15, 13, 14), enc_rr(OP_ADD, 16, 14, 13));
        idle(3);  // Operands now come from the regfile
        send_group(2'b11, enc_rr(OP_SUB, 17, 16, 15), enc_addi(17, 17, 1));
        send_group(2'b11, enc_rr(OP_ADD, 18, 17, 17), enc_rr(OP_OR, 19, 18, 11));
        drain();
        report_test("dependency_chains", e0);
    endtask

    task automatic test_zero_reg();
        int e0 = errors;
        send_group(2'b11, enc_addi(0, 5, 7), enc_rr(OP_ADD, 20, 0, 0));
        send_group(2'b11, 32'hffffffff, 32'h00000000);
        send_group(2'b11, enc_lu12i(0, 'h1), enc_rr(OP_OR, 21, 0, 5));
        drain();
        report_test("r0_and_unknown", e0);
    endtask

    task automatic test_random_stream();
        int e0 = errors;
        stall_seen = 1'b0;
        for (int k = 0; k < LEN_RAND / 2; k++) begin
            send_group(2'b11, rand_instr(), rand_instr());
        end
        drain();
        if (!stall_seen) begin
            $display("fetch stall never went high during the random stream");
            errors++;
        end
        report_test("random_backpressure", e0);
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        fetch_valid  = 2'b00;
        fetch_pc     = '0;
        fetch_instr0 = '0;
        fetch_instr1 = '0;
        next_pc      = 32'h1c000000;
        rng          = 32'hdf04b861;
        stall_seen   = 1'b0;
        errors       = 0;
        pass_count   = 0;
        fail_count   = 0;
        for (int r = 0; r < 32; r++) model_regs[r] = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        test_reset_quiet();
        test_independent();
        test_chains();
        test_zero_reg();
        test_random_stream();
        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (errors == 0 && fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the pipeline stopped", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule
